// ==== Makefile ====
# Verilator build for the VRAM fetch engine

TOP = vdma_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f \
		--Mdir obj_dir -o vdma_sim
	./obj_dir/vdma_sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Testbench failed" $(LOG); then exit 1; fi; \
	if ! grep -q "Testbench passed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)

// ==== source/line_dma.sv ====
// Per-line row scroll and object bus window
`timescale 1ns/1ns
`default_nettype none
`include "vdma_settings.svh"

module line_dma (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 pxl_cen,
    input  wire                 hb,
    input  wire  [8:0]          vrender,
    input  wire                 line_gnt,
    input  wire                 br_obj,
    input  wire                 br_pal,
    input  wire  [15:0]         vram_row_base,
    input  wire  [15:0]         row_offset,
    input  wire                 row_en,
    input  wire  [15:0]         hpos2,
    input  wire  [`VDMA_AW:1]   vram_obj_addr,
    input  wire  [`VDMA_DW-1:0] vram_data,
    output logic                hb_edge,
    output logic [8:0]          vrender_next,
    output logic                line_req,
    output logic [`VDMA_AW:1]   line_addr,
    output logic                line_done,
    output logic [15:0]         row_scr,
    output logic                bg_obj
);

    localparam logic [3:0] OBJ_START = 4'(`VDMA_OBJ_START);
    localparam logic [3:0] OBJ_END   = 4'(`VDMA_OBJ_END);
    localparam logic [3:0] LINE_LAST = 4'(`VDMA_LINE_LEN - 1);

    logic              last_hb;
    logic              hb_rise;
    logic              step;
    logic [3:0]        line_cnt;
    logic [9:0]        row_sum;
    logic [`VDMA_AW:1] row_addr;

    assign hb_rise = hb & ~last_hb;
    // Count only granted pixel strobes
    assign step    = line_req & line_gnt & pxl_cen;

    // Row scroll entry of the line about to be drawn
    assign row_sum  = row_offset[9:0] + {1'b0, vrender_next};
    assign row_addr = {vram_row_base[9:1], 8'd0} + {7'd0, row_sum};

    // Object engine drives the address once its window can open
    assign line_addr = (line_cnt >= OBJ_START) ? vram_obj_addr : row_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_hb   <= 1'b0;
            hb_edge   <= 1'b0;
            line_req  <= 1'b0;
            line_done <= 1'b0;
            line_cnt  <= 4'd0;
            bg_obj    <= 1'b0;
        end else begin
            last_hb   <= hb;
            hb_edge   <= hb_rise;
            line_done <= 1'b0;
            if (hb_rise) begin
                line_req <= 1'b1;
                line_cnt <= 4'd0;
                bg_obj   <= 1'b0;
            end else if (step) begin
                line_cnt <= line_cnt + 4'd1;
                // A pending palette request keeps the object engine out
                if (line_cnt == OBJ_START) begin
                    bg_obj <= br_obj & ~br_pal;
                end
                if (line_cnt == OBJ_END) begin
                    bg_obj <= 1'b0;
                end
                if (line_cnt == LINE_LAST) begin
                    line_req  <= 1'b0;
                    line_done <= 1'b1;
                    line_cnt  <= 4'd0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hb_rise) begin
            vrender_next <= vrender + 9'd1;
        end
        // Row word is sampled without vram_ok, three strobes give it time
        if (step && line_cnt == OBJ_START) begin
            row_scr <= {12'd0, hpos2[3:0]} + (row_en ? vram_data : 16'd0);
        end
    end

endmodule

`default_nettype wire

// ==== source/scroll_fetch.sv ====
// Scroll layer tile map fetch
`timescale 1ns/1ns
`default_nettype none
`include "vdma_settings.svh"

module scroll_fetch
    import vdma_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      pxl_cen,
    input  wire                      hb_edge,
    input  wire                      line_done,
    input  wire  [8:0]               vrender_next,
    input  wire                      scr_gnt,
    input  wire  [15:0]              vram1_base,
    input  wire  [15:0]              vram2_base,
    input  wire  [15:0]              vram3_base,
    input  wire  [15:0]              hpos1,
    input  wire  [15:0]              hpos2,
    input  wire  [15:0]              hpos3,
    input  wire  [15:0]              vpos1,
    input  wire  [15:0]              vpos2,
    input  wire  [15:0]              vpos3,
    input  wire                      vram_ok,
    output logic                     scr_req,
    output logic [`VDMA_AW:1]        scr_addr,
    output logic                     cache_we,
    output logic [`VDMA_CACHE_AW-1:0] cache_waddr,
    output layer_t                   cache_layer,
    output logic [2:0]               swap_req
);

    localparam logic [7:0] SCR2_LAST  = 8'(`VDMA_SCR2_LAST);
    localparam logic [7:0] SCR3_FIRST = SCR2_LAST + 8'd1;

    logic [2:0]  pending;
    layer_t      layer;
    logic [8:0]  scr_cnt;
    logic        written;
    logic [7:0]  scr_last;
    logic [10:0] vn;
    logic [10:0] hn;
    logic [15:0] vram_base;
    logic [15:0] vscr1;
    logic [15:0] vscr2;
    logic [15:0] vscr3;

    // Next layer to examine
    logic        sel_valid;
    logic        start;
    layer_t      sel_layer;
    logic [2:0]  sel_mask;
    logic        sel_aligned;
    logic [10:0] sel_vn;
    logic [10:0] sel_hn;
    logic [15:0] sel_base;
    logic [7:0]  sel_first;
    logic [7:0]  sel_last;

    logic [11:0] scan;
    logic [10:0] hstep;
    logic        fetch_addr;
    logic        fetch_ok;

    assign vscr1 = vpos1 + {7'd0, vrender_next};
    assign vscr2 = vpos2 + {7'd0, vrender_next};
    assign vscr3 = vpos3 + {7'd0, vrender_next};

    assign sel_valid = !scr_req && (pending != 3'd0) && !hb_edge && !line_done;
    assign start     = sel_valid && sel_aligned;

    always_comb begin
        if (pending[0]) begin
            sel_layer   = LAYER_SCR1;
            sel_mask    = 3'b001;
            sel_aligned = (vscr1[2:0] == 3'd0);
            sel_vn      = vscr1[10:0];
            sel_hn      = {hpos1[10:3], 3'd0};
            sel_base    = vram1_base;
            sel_first   = 8'd0;
            sel_last    = 8'd99;
        end else if (pending[1]) begin
            sel_layer   = LAYER_SCR2;
            sel_mask    = 3'b010;
            sel_aligned = (vscr2[3:0] == 4'd0);
            sel_vn      = vscr2[10:0];
            sel_hn      = {hpos2[10:4], 4'd0};
            sel_base    = vram2_base;
            sel_first   = 8'd128;
            sel_last    = SCR2_LAST;
        end else begin
            sel_layer   = LAYER_SCR3;
            sel_mask    = 3'b100;
            sel_aligned = (vscr3[3:0] == 4'd0);
            sel_vn      = vscr3[10:0];
            sel_hn      = {hpos3[10:5], 5'd0};
            sel_base    = vram3_base;
            sel_first   = SCR3_FIRST;
            sel_last    = 8'd255;
        end
    end

    // Map scan order, tile size 8, 16 or 32 pixels
    always_comb begin
        case (layer)
            LAYER_SCR1: begin
                scan  = {vn[8], hn[8:3], vn[7:3]};
                hstep = 11'd8;
            end
            LAYER_SCR2: begin
                scan  = {vn[9:8], hn[9:4], vn[7:4]};
                hstep = 11'd16;
            end
            default: begin
                scan  = {vn[10:8], hn[10:5], vn[7:5]};
                hstep = 11'd32;
            end
        endcase
    end

    assign fetch_addr  = scr_req && scr_gnt && !scr_cnt[0];
    assign fetch_ok    = scr_req && scr_gnt && scr_cnt[0] && !written && vram_ok;
    assign cache_layer = layer;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending  <= 3'd0;
            scr_req  <= 1'b0;
            layer    <= LAYER_SCR1;
            scr_cnt  <= 9'd0;
            written  <= 1'b0;
            cache_we <= 1'b0;
            swap_req <= 3'd0;
        end else begin
            cache_we <= 1'b0;
            if (hb_edge) begin
                // New line aborts whatever is left
                pending  <= 3'd0;
                scr_req  <= 1'b0;
                written  <= 1'b0;
                swap_req <= 3'd0;
            end else if (line_done) begin
                pending <= 3'b111;
            end else if (sel_valid) begin
                pending <= pending & ~sel_mask;
                if (sel_aligned) begin
                    scr_req  <= 1'b1;
                    layer    <= sel_layer;
                    scr_cnt  <= {sel_first, 1'b0};
                    written  <= 1'b0;
                    swap_req <= swap_req | sel_mask;
                end
            end else if (scr_req && scr_gnt) begin
                if (!scr_cnt[0]) begin
                    if (pxl_cen) begin
                        scr_cnt <= scr_cnt + 9'd1;
                    end
                end else if (!written) begin
                    if (vram_ok) begin
                        cache_we <= 1'b1;
                        written  <= 1'b1;
                    end
                end else if (pxl_cen) begin
                    written <= 1'b0;
                    scr_cnt <= scr_cnt + 9'd1;
                    if (scr_cnt[8:1] == scr_last) begin
                        scr_req <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            vn        <= sel_vn;
            hn        <= sel_hn;
            vram_base <= sel_base;
            scr_last  <= sel_last;
        end else if (fetch_addr) begin
            scr_addr <= {vram_base[9:1], 8'd0} + {4'd0, scan, scr_cnt[1]};
        end else if (fetch_ok) begin
            cache_waddr <= scr_cnt[8:1];
            // Second word of a pair closes the tile
            if (scr_cnt[1]) begin
                hn <= hn + hstep;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/tile_cache.sv ====
// Double-banked scroll tile cache
`timescale 1ns/1ns
`default_nettype none
`include "vdma_settings.svh"

module tile_cache
    import vdma_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       hb_edge,
    input  wire                       cache_we,
    input  wire [`VDMA_CACHE_AW-1:0]  cache_waddr,
    input  wire layer_t               cache_layer,
    input  wire [2:0]                 swap_req,
    input  wire [`VDMA_DW-1:0]        vram_data,
    input  wire [`VDMA_CACHE_AW-1:0]  tile_addr,
    output logic [`VDMA_DW-1:0]       tile_data
);

    localparam logic [7:0] SCR2_LAST = 8'(`VDMA_SCR2_LAST);

    logic [`VDMA_DW-1:0] mem [0:2**(`VDMA_CACHE_AW+1)-1];
    logic [2:0]          active;
    logic                wr_bank;
    logic                rd_bank;

    // Fetch fills the bank the renderer is not using
    always_comb begin
        case (cache_layer)
            LAYER_SCR1: wr_bank = ~active[0];
            LAYER_SCR2: wr_bank = ~active[1];
            default:    wr_bank = ~active[2];
        endcase
    end

    always_comb begin
        if (!tile_addr[7]) begin
            rd_bank = active[0];
        end else if (tile_addr <= SCR2_LAST) begin
            rd_bank = active[1];
        end else begin
            rd_bank = active[2];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 3'd0;
        end else if (hb_edge) begin
            active <= active ^ swap_req;
        end
    end

    always_ff @(posedge clk) begin
        if (cache_we) begin
            mem[{wr_bank, cache_waddr}] <= vram_data;
        end
        tile_data <= mem[{rd_bank, tile_addr}];
    end

endmodule

`default_nettype wire

// ==== source/vdma_pkg.sv ====
// Video RAM fetch engine types
`default_nettype none

package vdma_pkg;

    // Current holder of the VRAM bus
    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_LINE,
        OWNER_PAL,
        OWNER_SCROLL
    } bus_owner_t;

    // Scroll layer being fetched
    typedef enum logic [1:0] {
        LAYER_SCR1,
        LAYER_SCR2,
        LAYER_SCR3
    } layer_t;

endpackage

`default_nettype wire

// ==== source/vdma_settings.svh ====
// Video RAM fetch engine parameters
`ifndef VDMA_SETTINGS_SVH
`define VDMA_SETTINGS_SVH

// VRAM word address, bits 17 down to 1
`define VDMA_AW 17

// VRAM and cache data width
`define VDMA_DW 16

// Cache address width of one bank
`define VDMA_CACHE_AW 8

// Line phase pixel counts
`define VDMA_OBJ_START 3
`define VDMA_OBJ_END 11
`define VDMA_LINE_LEN 16

// Cache index ranges per layer
// layer 1 ends at 99, layer 3 starts right after layer 2
`define VDMA_SCR2_LAST 225

`endif

// ==== source/vdma_top.sv ====
// Video RAM fetch engine top level
`timescale 1ns/1ns
`default_nettype none
`include "vdma_settings.svh"

module vdma_top
    import vdma_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    // Video timing
    input  wire                       pxl_cen,
    input  wire                       hb,
    input  wire  [8:0]                vrender,
    // Scroll registers
    input  wire  [15:0]               vram1_base,
    input  wire  [15:0]               vram2_base,
    input  wire  [15:0]               vram3_base,
    input  wire  [15:0]               hpos1,
    input  wire  [15:0]               hpos2,
    input  wire  [15:0]               hpos3,
    input  wire  [15:0]               vpos1,
    input  wire  [15:0]               vpos2,
    input  wire  [15:0]               vpos3,
    // Row scroll
    input  wire  [15:0]               vram_row_base,
    input  wire  [15:0]               row_offset,
    input  wire                       row_en,
    output wire  [15:0]               row_scr,
    // Renderer side of the cache
    input  wire  [`VDMA_CACHE_AW-1:0] tile_addr,
    output wire  [`VDMA_DW-1:0]       tile_data,
    // Object and palette engines
    input  wire                       br_obj,
    output wire                       bg_obj,
    input  wire  [`VDMA_AW:1]         vram_obj_addr,
    input  wire                       br_pal,
    output wire                       bg_pal,
    input  wire  [`VDMA_AW:1]         vram_pal_addr,
    // VRAM bus
    output wire  [`VDMA_AW:1]         vram_addr,
    input  wire  [`VDMA_DW-1:0]       vram_data,
    input  wire                       vram_ok,
    output wire                       vram_cs,
    output wire                       br,
    input  wire                       bg
);

    wire                      hb_edge;
    wire [8:0]                vrender_next;
    wire                      line_req;
    wire [`VDMA_AW:1]         line_addr;
    wire                      line_done;
    wire                      line_gnt;
    wire                      scr_req;
    wire [`VDMA_AW:1]         scr_addr;
    wire                      scr_gnt;
    wire                      cache_we;
    wire [`VDMA_CACHE_AW-1:0] cache_waddr;
    wire layer_t              cache_layer;
    wire [2:0]                swap_req;

    // Port names match the nets above one to one
    line_dma i_line_dma (.*);

    scroll_fetch i_scroll_fetch (.*);

    tile_cache i_tile_cache (.*);

    // Owner is only looked at inside the arbiter
    vram_arbiter i_vram_arbiter (
        .owner (),
        .*
    );

endmodule

`default_nettype wire

// ==== source/vram_arbiter.sv ====
// VRAM bus owner selection
`timescale 1ns/1ns
`default_nettype none
`include "vdma_settings.svh"

module vram_arbiter
    import vdma_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                line_req,
    input  wire [`VDMA_AW:1]   line_addr,
    input  wire                scr_req,
    input  wire [`VDMA_AW:1]   scr_addr,
    input  wire                br_pal,
    input  wire [`VDMA_AW:1]   vram_pal_addr,
    input  wire                bg,
    output bus_owner_t         owner,
    output logic               line_gnt,
    output logic               scr_gnt,
    output logic               bg_pal,
    output logic               br,
    output logic               vram_cs,
    output logic [`VDMA_AW:1]  vram_addr
);

    bus_owner_t owner_next;

    // Line phase wins at once, others keep the bus until they let go
    always_comb begin
        if (line_req) begin
            owner_next = OWNER_LINE;
        end else if (owner == OWNER_PAL && br_pal) begin
            owner_next = OWNER_PAL;
        end else if (owner == OWNER_SCROLL && scr_req) begin
            owner_next = OWNER_SCROLL;
        end else if (br_pal) begin
            owner_next = OWNER_PAL;
        end else if (scr_req) begin
            owner_next = OWNER_SCROLL;
        end else begin
            owner_next = OWNER_NONE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner  <= OWNER_NONE;
            br     <= 1'b0;
            bg_pal <= 1'b0;
        end else begin
            owner  <= owner_next;
            br     <= (owner_next != OWNER_NONE);
            // Palette engine sees its grant one clock late
            bg_pal <= (owner == OWNER_PAL) && bg;
        end
    end

    assign vram_cs  = br;
    assign line_gnt = (owner == OWNER_LINE) && bg;
    assign scr_gnt  = (owner == OWNER_SCROLL) && bg;

    always_comb begin
        case (owner)
            OWNER_LINE:   vram_addr = line_addr;
            OWNER_PAL:    vram_addr = vram_pal_addr;
            OWNER_SCROLL: vram_addr = scr_addr;
            default:      vram_addr = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/vdma_pkg.sv
source/line_dma.sv
source/scroll_fetch.sv
source/tile_cache.sv
source/vram_arbiter.sv
source/vdma_top.sv
tests/vdma_chk.sv
tests/vdma_tb.sv

// ==== tests/vdma_chk.sv ====
// Bus and grant rule checks
`timescale 1ns/1ns
`default_nettype none

module vdma_chk
    import vdma_pkg::*;
(
    input wire        clk,
    input wire        rst,
    input wire        bg,
    input wire        br,
    input wire        vram_cs,
    input wire        line_gnt,
    input wire        scr_gnt,
    input bus_owner_t owner
);

    // Chip select is the bus request itself
    cs_follows_br: assert property (
        @(posedge clk) disable iff (rst) vram_cs == br
    ) else $error("vram_cs differs from br");

    // Line phase and scroll fetch never share the bus
    one_grant: assert property (
        @(posedge clk) disable iff (rst) !(line_gnt && scr_gnt)
    ) else $error("line_gnt and scr_gnt high together");

    // No grant without the bus and an owner
    grant_needs_bg: assert property (
        @(posedge clk) disable iff (rst)
        (line_gnt || scr_gnt) |-> (bg && owner != OWNER_NONE)
    ) else $error("grant high while bg is low or no owner");

endmodule

`default_nettype wire

// ==== tests/vdma_tb.sv ====
// Video RAM fetch engine testbench
`timescale 1ns/1ns
`default_nettype none
`include "vdma_settings.svh"

module vdma_tb;

    localparam int LINE_CLKS = 2600;
    localparam int NUM_LINES = 8;

    logic clk, rst, pxl_cen, hb, row_en, br_obj, br_pal, vram_ok, bg;
    logic [8:0]                vrender;
    logic [15:0]               vram1_base, vram2_base, vram3_base;
    logic [15:0]               hpos1, hpos2, hpos3, vpos1, vpos2, vpos3;
    logic [15:0]               vram_row_base, row_offset;
    logic [`VDMA_CACHE_AW-1:0] tile_addr;
    logic [`VDMA_AW:1]         vram_obj_addr, vram_pal_addr, rd_addr;
    logic [`VDMA_DW-1:0]       vram_data;
    wire  [15:0]               row_scr;
    wire  [`VDMA_DW-1:0]       tile_data;
    wire  [`VDMA_AW:1]         vram_addr;
    wire                       bg_obj, bg_pal, vram_cs, br;

    integer      seed;
    int          errors;
    int          cyc;
    int          rd_wait;
    logic [2:0]  bg_wait;
    logic        rd_valid, obj_seen, timed_out;
    logic [2:0]  fetched, shown_valid;
    logic [15:0] pend_vscr [3];
    logic [15:0] shown_vscr [3];

    vdma_top i_vdma_top (.*);

    bind vram_arbiter vdma_chk i_vdma_chk (
        .clk(clk), .rst(rst), .bg(bg), .br(br), .vram_cs(vram_cs),
        .line_gnt(line_gnt), .scr_gnt(scr_gnt), .owner(owner)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // VRAM contents as a function of the whole word address
    function automatic logic [15:0] scramble(input logic [`VDMA_AW:1] a);
        return (a[16:1] * 16'h9e37) ^ {a[17], a[16:2]} ^ 16'h5a3c;
    endfunction

    // Expected cache word, layer taken from the index range
    function automatic logic [15:0] tile_ref(input logic [7:0] idx, input logic [15:0] vscr);
        logic [10:0]       vn;
        logic [10:0]       hn;
        logic [7:0]        pair;
        logic [11:0]       scan;
        logic [15:0]       base;
        logic [`VDMA_AW:1] addr;
        vn = vscr[10:0];
        if (idx < 8'd100) begin
            pair = idx >> 1;
            hn   = {hpos1[10:3], 3'd0} + {pair, 3'd0};
            scan = {vn[8], hn[8:3], vn[7:3]};
            base = vram1_base;
        end else if (idx <= 8'd225) begin
            pair = (idx - 8'd128) >> 1;
            hn   = {hpos2[10:4], 4'd0} + {pair[6:0], 4'd0};
            scan = {vn[9:8], hn[9:4], vn[7:4]};
            base = vram2_base;
        end else begin
            pair = (idx - 8'd226) >> 1;
            hn   = {hpos3[10:5], 5'd0} + {pair[5:0], 5'd0};
            scan = {vn[10:8], hn[10:5], vn[7:5]};
            base = vram3_base;
        end
        addr = {base[9:1], 8'd0} + {4'd0, scan, idx[0]};
        return scramble(addr);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic expect_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(posedge clk) begin
        #2;
        pxl_cen = rst ? 1'b0 : ~pxl_cen;
    end

    // Bus grant follows the request after a few clocks
    always @(posedge clk) begin
        #2;
        if (rst) begin
            bg      = 1'b0;
            bg_wait = 3'd0;
        end else if (bg != br) begin
            if (bg_wait == 3'd0) begin
                bg_wait = 3'(1 + ($random(seed) & 3));
            end
            if (bg_wait == 3'd1) begin
                bg      = br;
                bg_wait = 3'd0;
            end else begin
                bg_wait = bg_wait - 3'd1;
            end
        end
    end

    // VRAM read takes two or three clocks after a new address
    always @(posedge clk) begin
        #2;
        if (rst) begin
            rd_valid = 1'b0;
            rd_wait  = 0;
        end else if (vram_cs && (!rd_valid || vram_addr != rd_addr)) begin
            rd_addr  = vram_addr;
            rd_valid = 1'b1;
            vram_ok  = 1'b0;
            rd_wait  = 2 + ($random(seed) & 1);
        end else if (rd_wait != 0) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
                vram_data = scramble(rd_addr);
                vram_ok   = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && bg_obj) begin
            obj_seen = 1'b1;
            if (vram_addr !== vram_obj_addr) begin
                $display("** Error vram_addr in object window: got %h, expected %h",
                         vram_addr, vram_obj_addr);
                errors++;
            end
        end
        if (!rst && br_pal && bg_pal && vram_addr !== vram_pal_addr) begin
            $display("** Error vram_addr in palette grant: got %h, expected %h",
                     vram_addr, vram_pal_addr);
            errors++;
        end
    end

    task automatic run_line(input int line);
        int          start;
        int          n;
        int          k;
        logic [8:0]  nxt;
        logic [`VDMA_AW:1] row_addr;
        start = cyc;
        // Banks fetched last line become visible at this hb
        for (k = 0; k < 3; k++) begin
            if (fetched[k]) begin
                shown_vscr[k]  = pend_vscr[k];
                shown_valid[k] = 1'b1;
            end
        end
        vrender = vrender + 9'd1;
        nxt     = vrender + 9'd1;
        for (k = 0; k < 3; k++) begin
            fetched[k]   = ($random(seed) & 3) != 0;
            pend_vscr[k] = 16'($random(seed));
            pend_vscr[k][3:0] = fetched[k] ? 4'd0 : 4'd5;
        end
        vpos1    = pend_vscr[0] - {7'd0, nxt};
        vpos2    = pend_vscr[1] - {7'd0, nxt};
        vpos3    = pend_vscr[2] - {7'd0, nxt};
        br_obj   = (line % 2) == 0;
        row_en   = 1'($random(seed));
        obj_seen = 1'b0;
        hb = 1'b1;
        repeat (4) next_cycle();
        hb = 1'b0;

        n = 0;
        while (!i_vdma_top.line_done && n < 200) begin
            next_cycle();
            n++;
        end
        if (!i_vdma_top.line_done) begin
            $display("Timeout: line phase did not finish");
            timed_out = 1'b1;
            return;
        end
        // Row scroll entry of the next line inside a 256-word block
        row_addr = {vram_row_base[9:1], 8'd0} + {1'b0, row_offset} + {8'd0, nxt};
        expect_eq("row_scr", row_scr,
                  {12'd0, hpos2[3:0]} + (row_en ? scramble(row_addr) : 16'd0));
        if (obj_seen != br_obj) begin
            $display("Object grant wrong on line %0d: br_obj %0d but bg_obj seen %0d",
                     line, br_obj, obj_seen);
            errors++;
        end

        // Renderer view of the banks filled on the previous line
        for (n = 0; n < 256; n++) begin
            k = (n < 100) ? 0 : ((n <= 225) ? 1 : 2);
            if ((n >= 100 && n < 128) || !shown_valid[k]) begin
                continue;
            end
            tile_addr = 8'(n);
            next_cycle();
            expect_eq("tile_data", tile_data, tile_ref(8'(n), shown_vscr[k]));
        end

        n = 0;
        while ((i_vdma_top.i_scroll_fetch.pending != 3'd0 || i_vdma_top.scr_req) && n < 2200) begin
            next_cycle();
            n++;
        end
        if (i_vdma_top.i_scroll_fetch.pending != 3'd0 || i_vdma_top.scr_req) begin
            $display("Timeout: scroll fetch did not finish");
            timed_out = 1'b1;
            return;
        end

        // Palette engine takes the idle bus
        br_pal = 1'b1;
        n = 0;
        while (!bg_pal && n < 50) begin
            next_cycle();
            n++;
        end
        if (!bg_pal) begin
            $display("Timeout: bg_pal never rose");
            timed_out = 1'b1;
            return;
        end
        repeat (8) next_cycle();
        br_pal = 1'b0;
        n = 0;
        while (bg_pal && n < 50) begin
            next_cycle();
            n++;
        end
        if (bg_pal) begin
            $display("Timeout: bg_pal stayed high after br_pal dropped");
            timed_out = 1'b1;
            return;
        end
        while (cyc < start + LINE_CLKS) begin
            next_cycle();
        end
    endtask

    initial begin
        seed        = 32'hb636b5b7;
        errors      = 0;
        timed_out   = 1'b0;
        fetched     = 3'd0;
        shown_valid = 3'd0;
        rst         = 1'b1;
        pxl_cen     = 1'b0;
        hb          = 1'b0;
        vrender     = 9'd20;
        row_en      = 1'b0;
        br_obj      = 1'b0;
        br_pal      = 1'b0;
        vram_ok     = 1'b0;
        vram_data   = 16'd0;
        bg          = 1'b0;
        tile_addr   = 8'd0;
        vpos1       = 16'd0;
        vpos2       = 16'd0;
        vpos3       = 16'd0;
        vram1_base    = 16'($random(seed));
        vram2_base    = 16'($random(seed));
        vram3_base    = 16'($random(seed));
        hpos1         = 16'($random(seed));
        hpos2         = 16'($random(seed));
        hpos3         = 16'($random(seed));
        vram_row_base = 16'($random(seed));
        row_offset    = 16'($random(seed) & 63);
        vram_obj_addr = 17'($random(seed));
        vram_pal_addr = 17'($random(seed));
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        expect_eq("br", {15'd0, br}, 16'd0);
        expect_eq("vram_cs", {15'd0, vram_cs}, 16'd0);
        expect_eq("bg_obj", {15'd0, bg_obj}, 16'd0);
        expect_eq("bg_pal", {15'd0, bg_pal}, 16'd0);
        for (int line = 0; line < NUM_LINES && !timed_out; line++) begin
            run_line(line);
        end
        $display("Errors: %0d, timeouts: %0d", errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
